// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_system
FILELIST   := vlog.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: block_ram.sv
`default_nettype none

`include "mem_sys_config.svh"

module block_ram (
	input  logic                  clk,
	input  mem_sys_pkg::bus_req_t ram_req,
	output mem_sys_pkg::bus_rsp_t ram_rsp
);

	localparam int WORDS = 1 << `MEM_ADDR_BITS;

	logic [31:0] mem [WORDS];
	logic [31:0] rdata_q;
	logic        ready_q;
	logic        start;

	// A held request is served once, the ready cycle does not restart it
	assign start = ram_req.valid & ~ready_q;

	always_ff @(posedge clk)
	begin
		ready_q <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start && !ram_req.write)
			rdata_q <= mem[ram_req.addr];
	end

	// Byte lanes written independently
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 4; b++)
		begin
			if (start && ram_req.write && ram_req.strb[b])
				mem[ram_req.addr][8*b +: 8] <= ram_req.wdata[8*b +: 8];
		end
	end

	assign ram_rsp.ready = ready_q;
	assign ram_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_sys_pkg::bus_req_t i_bus_req,
	output mem_sys_pkg::bus_rsp_t i_bus_rsp,
	input  mem_sys_pkg::bus_req_t d_bus_req,
	output mem_sys_pkg::bus_rsp_t d_bus_rsp,
	output mem_sys_pkg::bus_req_t ram_req,
	input  mem_sys_pkg::bus_rsp_t ram_rsp
);

	logic busy;     // A transaction owns the RAM
	logic owner;    // 0 fetch side, 1 data side
	logic last;     // Side served most recently
	logic pick;     // Winner when idle
	logic sel;
	logic active;
	logic i_grant;
	logic d_grant;

	// Round robin on a tie, otherwise whoever asks
	assign pick = (i_bus_req.valid & d_bus_req.valid) ? ~last : d_bus_req.valid;

	assign sel     = busy ? owner : pick;
	assign active  = busy | i_bus_req.valid | d_bus_req.valid;
	assign i_grant = active & ~sel;
	assign d_grant = active & sel;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy  <= 1'b0;
			owner <= 1'b0;
			last  <= 1'b0;
		end
		else if (!busy)
		begin
			if (i_bus_req.valid | d_bus_req.valid)
			begin
				busy  <= 1'b1;
				owner <= pick;
			end
		end
		else if (ram_rsp.ready)
		begin
			busy <= 1'b0;     // Free again next cycle
			last <= owner;
		end
	end

	always_comb
	begin
		ram_req = '0;
		if (i_grant)
			ram_req = i_bus_req;
		else if (d_grant)
			ram_req = d_bus_req;
	end

	// Response goes back to the owner alone
	always_comb
	begin
		i_bus_rsp = '0;
		d_bus_rsp = '0;
		if (i_grant)
			i_bus_rsp = ram_rsp;
		if (d_grant)
			d_bus_rsp = ram_rsp;
	end

endmodule

`default_nettype wire

// File: data_port.sv
`default_nettype none

`include "mem_sys_config.svh"

module data_port (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_sys_pkg::apb_req_t apb_req,
	output mem_sys_pkg::apb_rsp_t apb_rsp,
	output mem_sys_pkg::bus_req_t bus_req,
	input  mem_sys_pkg::bus_rsp_t bus_rsp
);

	typedef enum logic {S_IDLE, S_WAIT} state_t;

	state_t      state;
	logic        done_q;    // Completion shown on APB this cycle
	logic [31:0] rdata_q;
	logic        access;
	logic        in_range;
	logic        start;

	assign access   = apb_req.psel & apb_req.penable;
	assign in_range = apb_req.paddr[31:`MEM_BYTE_MSB+1] == '0;
	assign start    = (state == S_IDLE) & access & in_range & ~done_q;

	// Word request straight from the stable APB fields
	always_comb
	begin
		bus_req.valid = (state == S_WAIT) | start;
		bus_req.write = apb_req.pwrite;
		bus_req.addr  = apb_req.paddr[`MEM_BYTE_MSB:`WORD_OFFSET_BITS];
		bus_req.wdata = apb_req.pwdata;
		bus_req.strb  = apb_req.pwrite ? apb_req.pstrb : 4'hf;
	end

	always_comb
	begin
		apb_rsp.pready  = done_q;
		apb_rsp.prdata  = rdata_q;
		apb_rsp.pslverr = 1'b0;
		if (state == S_IDLE && access && !done_q && !in_range)
		begin
			apb_rsp.pready  = 1'b1;  // Rejected without a bus cycle
			apb_rsp.pslverr = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= S_IDLE;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (start)
				state <= S_WAIT;
			else if (state == S_WAIT && bus_rsp.ready)
			begin
				state  <= S_IDLE;
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_WAIT && bus_rsp.ready)
			rdata_q <= bus_rsp.rdata;
	end

endmodule

`default_nettype wire

// File: icache.sv
`default_nettype none

`include "mem_sys_config.svh"

module icache (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_sys_pkg::apb_req_t apb_req,
	output mem_sys_pkg::apb_rsp_t apb_rsp,
	output mem_sys_pkg::bus_req_t bus_req,
	input  mem_sys_pkg::bus_rsp_t bus_rsp
);

	localparam int OFFSET_BITS = $clog2(`ICACHE_LINE_WORDS);
	localparam int INDEX_BITS  = $clog2(`ICACHE_LINES);
	localparam int TAG_BITS    = `MEM_ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam logic [OFFSET_BITS-1:0] LAST_WORD = OFFSET_BITS'(`ICACHE_LINE_WORDS - 1);

	typedef enum logic [1:0] {S_LOOKUP, S_FILL, S_RESPOND} state_t;

	logic [TAG_BITS-1:0] tag_mem  [`ICACHE_LINES];
	logic [31:0]         data_mem [`ICACHE_LINES * `ICACHE_LINE_WORDS];
	logic [`ICACHE_LINES-1:0] line_valid;

	state_t                    state;
	logic [OFFSET_BITS-1:0]    fill_cnt;   // Next word of the line to fetch
	logic [`MEM_ADDR_BITS-1:0] waddr;
	logic [TAG_BITS-1:0]       tag;
	logic [INDEX_BITS-1:0]     index;
	logic [OFFSET_BITS-1:0]    offset;
	logic                      access;
	logic                      bad;
	logic                      hit;
	logic [31:0]               line_word;

	assign waddr  = apb_req.paddr[`MEM_BYTE_MSB:`WORD_OFFSET_BITS];
	assign tag    = waddr[`MEM_ADDR_BITS-1 -: TAG_BITS];
	assign index  = waddr[OFFSET_BITS +: INDEX_BITS];
	assign offset = waddr[OFFSET_BITS-1:0];

	assign access    = apb_req.psel & apb_req.penable;
	// Read only, and nothing beyond the RAM
	assign bad       = apb_req.pwrite | (apb_req.paddr[31:`MEM_BYTE_MSB+1] != '0);
	assign hit       = line_valid[index] & (tag_mem[index] == tag);
	assign line_word = data_mem[{index, offset}];

	always_comb
	begin
		apb_rsp = '0;
		case (state)
			S_LOOKUP:
				if (access)
				begin
					if (bad)
					begin
						apb_rsp.pready  = 1'b1;
						apb_rsp.pslverr = 1'b1;
					end
					else if (hit)
					begin
						apb_rsp.pready = 1'b1;
						apb_rsp.prdata = line_word;
					end
				end
			S_RESPOND:
			begin
				apb_rsp.pready = 1'b1;   // Line just filled
				apb_rsp.prdata = line_word;
			end
			default: ;
		endcase
	end

	// Line fill walks the words of the line in order
	always_comb
	begin
		bus_req       = '0;
		bus_req.valid = (state == S_FILL);
		bus_req.addr  = {tag, index, fill_cnt};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= S_LOOKUP;
			fill_cnt   <= '0;
			line_valid <= '0;
		end
		else
		begin
			case (state)
				S_LOOKUP:
					if (access && !bad && !hit)
					begin
						state      <= S_FILL;
						fill_cnt   <= '0;
						line_valid[index] <= 1'b0;
					end
				S_FILL:
					if (bus_rsp.ready)
					begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == LAST_WORD)
						begin
							line_valid[index] <= 1'b1;
							state             <= S_RESPOND;
						end
					end
				default:
					state <= S_LOOKUP;
			endcase
		end
	end

	// Tag and line words
	always_ff @(posedge clk)
	begin
		if (state == S_FILL && bus_rsp.ready)
		begin
			data_mem[{index, fill_cnt}] <= bus_rsp.rdata;
			if (fill_cnt == LAST_WORD)
				tag_mem[index] <= tag;
		end
	end

endmodule

`default_nettype wire

// File: mem_sys_config.svh
`ifndef MEM_SYS_CONFIG_SVH
`define MEM_SYS_CONFIG_SVH

// RAM size in word-address bits, 1024 words of 32 bits
`define MEM_ADDR_BITS 10

// Instruction cache geometry
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// Byte address bits that select a byte inside a word
`define WORD_OFFSET_BITS 2

// Highest byte address bit that still falls inside the RAM
`define MEM_BYTE_MSB (`MEM_ADDR_BITS + `WORD_OFFSET_BITS - 1)

`endif

// File: mem_sys_pkg.sv
`default_nettype none

`include "mem_sys_config.svh"

package mem_sys_pkg;

	// Processor side of APB, driven by the requester
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;    // Byte address
		logic [31:0] pwdata;
		logic [3:0]  pstrb;
	} apb_req_t;

	// Completer side of APB
	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;  // Only meaningful with pready
	} apb_rsp_t;

	// One word transaction on the shared RAM bus
	typedef struct packed {
		logic                      valid;
		logic                      write;
		logic [`MEM_ADDR_BITS-1:0] addr;   // Word address
		logic [31:0]               wdata;
		logic [3:0]                strb;
	} bus_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: mem_system.sv
`default_nettype none

module mem_system (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_sys_pkg::apb_req_t i_req,
	output mem_sys_pkg::apb_rsp_t i_rsp,
	input  mem_sys_pkg::apb_req_t d_req,
	output mem_sys_pkg::apb_rsp_t d_rsp
);

	import mem_sys_pkg::*;

	bus_req_t i_bus_req;   // Line fills from the instruction cache
	bus_rsp_t i_bus_rsp;
	bus_req_t d_bus_req;   // Uncached data accesses
	bus_rsp_t d_bus_rsp;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;

	icache u_icache (
		.clk     (clk),
		.reset   (reset),
		.apb_req (i_req),
		.apb_rsp (i_rsp),
		.bus_req (i_bus_req),
		.bus_rsp (i_bus_rsp)
	);

	data_port u_data_port (
		.clk     (clk),
		.reset   (reset),
		.apb_req (d_req),
		.apb_rsp (d_rsp),
		.bus_req (d_bus_req),
		.bus_rsp (d_bus_rsp)
	);

	bus_arbiter u_bus_arbiter (
		.clk       (clk),
		.reset     (reset),
		.i_bus_req (i_bus_req),
		.i_bus_rsp (i_bus_rsp),
		.d_bus_req (d_bus_req),
		.d_bus_rsp (d_bus_rsp),
		.ram_req   (ram_req),
		.ram_rsp   (ram_rsp)
	);

	block_ram u_block_ram (
		.clk     (clk),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp)
	);

endmodule

`default_nettype wire

// File: mem_system_properties.sv
`default_nettype none

module mem_system_properties (
	input logic                  clk,
	input logic                  reset,
	input mem_sys_pkg::bus_req_t i_bus_req,
	input mem_sys_pkg::bus_req_t d_bus_req,
	input mem_sys_pkg::bus_req_t ram_req,
	input mem_sys_pkg::bus_rsp_t ram_rsp,
	input mem_sys_pkg::bus_rsp_t i_bus_rsp,
	input mem_sys_pkg::bus_rsp_t d_bus_rsp,
	input logic                  busy,
	input logic                  owner,
	input logic                  i_grant,
	input logic                  d_grant
);

	timeunit 1ns;
	timeprecision 100ps;

	logic d_served;   // Data side took the latest ready
	logic tie;

	assign tie = !busy && i_bus_req.valid && d_bus_req.valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			d_served <= 1'b0;
		else if (i_bus_rsp.ready)
			d_served <= 1'b0;
		else if (d_bus_rsp.ready)
			d_served <= 1'b1;
	end

	// Ties go to the side not served last
	grant_onehot: assert property (@(posedge clk) disable iff (reset)
		ram_req.valid |-> $onehot({i_grant, d_grant})
			&& (!tie || (d_served ? i_grant : d_grant)))
		else $error("RAM request without exactly one grant or with an unfair tie break");

	owner_held: assert property (@(posedge clk) disable iff (reset)
		ram_req.valid && !ram_rsp.ready |=> $stable(ram_req) && $stable({i_grant, d_grant}))
		else $error("Request or grant changed before the RAM answered");

	// Fixed one-cycle RAM response
	ready_latency: assert property (@(posedge clk) disable iff (reset)
		ram_req.valid && !ram_rsp.ready |=> ram_rsp.ready)
		else $error("RAM ready did not follow the request by one cycle");

	i_ready_owned: assert property (@(posedge clk) disable iff (reset)
		i_bus_rsp.ready |-> busy && !owner)
		else $error("Fetch side saw ready without owning the RAM");

	d_ready_owned: assert property (@(posedge clk) disable iff (reset)
		d_bus_rsp.ready |-> busy && owner)
		else $error("Data side saw ready without owning the RAM");

endmodule

bind bus_arbiter mem_system_properties u_arb_props (
	.clk       (clk),
	.reset     (reset),
	.i_bus_req (i_bus_req),
	.d_bus_req (d_bus_req),
	.ram_req   (ram_req),
	.ram_rsp   (ram_rsp),
	.i_bus_rsp (i_bus_rsp),
	.d_bus_rsp (d_bus_rsp),
	.busy      (busy),
	.owner     (owner),
	.i_grant   (i_grant),
	.d_grant   (d_grant)
);

`default_nettype wire

// File: tb_mem_system.sv
`default_nettype none

`include "mem_sys_config.svh"

module tb_mem_system;

	timeunit 1ns;
	timeprecision 100ps;

	import mem_sys_pkg::*;

	typedef logic [`MEM_ADDR_BITS-1:0] waddr_t;

	localparam int WORDS      = 1 << `MEM_ADDR_BITS;
	localparam int REGION     = 256;   // Fetch region below, data region above
	localparam int ALIAS_STEP = `ICACHE_LINES * `ICACHE_LINE_WORDS;
	localparam int N_WRITES   = 200;
	localparam int N_PAR      = 150;   // Per side, 300 in total
	// Preload, random writes and parallel phase at roughly 5 cycles per word
	localparam int MAX_CYCLES = 20000;
	localparam logic [31:0] RAM_BYTES = 32'(WORDS * 4);

	logic     clk;
	logic     reset;
	apb_req_t i_req;
	apb_rsp_t i_rsp;
	apb_req_t d_req;
	apb_rsp_t d_rsp;

	logic [15:0] lfsr;
	int          cycles;
	logic [31:0] model_mem [WORDS];
	logic        line_ok   [`ICACHE_LINES];
	int          line_base [`ICACHE_LINES];   // First word address of the held line
	logic [31:0] line_data [`ICACHE_LINES][`ICACHE_LINE_WORDS];
	waddr_t      par_fetch [N_PAR];
	waddr_t      par_addr  [N_PAR];
	logic [31:0] par_data  [N_PAR];
	logic [3:0]  par_strb  [N_PAR];
	logic        par_write [N_PAR];

	mem_system i_dut (
		.clk   (clk),
		.reset (reset),
		.i_req (i_req),
		.i_rsp (i_rsp),
		.d_req (d_req),
		.d_rsp (d_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, an APB access never completed", cycles);
		stop_with_failure();
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Cached copy on a hit, otherwise a line fill from the memory model
	function automatic logic [31:0] exp_fetch(input waddr_t wa);
		int off;
		int idx;
		int base;
		off  = int'(wa) % `ICACHE_LINE_WORDS;
		base = int'(wa) - off;
		idx  = (int'(wa) / `ICACHE_LINE_WORDS) % `ICACHE_LINES;
		if (!line_ok[idx] || line_base[idx] != base)
		begin
			for (int w = 0; w < `ICACHE_LINE_WORDS; w++)
				line_data[idx][w] = model_mem[base + w];
			line_ok[idx]   = 1'b1;
			line_base[idx] = base;
		end
		return line_data[idx][off];
	endfunction

	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_rdata(input string name, input apb_rsp_t rsp, input logic [31:0] exp);
		if (rsp.pslverr !== 1'b0 || rsp.prdata !== exp)
		begin
			$display("ERROR %s: expected %h (pslverr 0), actual %h (pslverr %b)",
				name, exp, rsp.prdata, rsp.pslverr);
			stop_with_failure();
		end
	endtask

	task automatic check_err(input string name, input apb_rsp_t rsp, input logic exp);
		if (rsp.pslverr !== exp)
		begin
			$display("ERROR %s: expected pslverr %b, actual %b", name, exp, rsp.pslverr);
			stop_with_failure();
		end
	endtask

	task automatic check_idle(input string name, input apb_rsp_t rsp);
		if (rsp.pready !== 1'b0 || rsp.pslverr !== 1'b0)
		begin
			$display("ERROR %s: expected pready 0 pslverr 0, actual pready %b pslverr %b",
				name, rsp.pready, rsp.pslverr);
			stop_with_failure();
		end
	endtask

	task automatic drive_side(input bit data_side, input apb_req_t req);
		if (data_side)
			d_req = req;
		else
			i_req = req;
	endtask

	// Setup and access phases, then wait for pready sampled mid-cycle
	task automatic apb_access(input bit data_side, input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb, output apb_rsp_t rsp);
		apb_req_t req;
		req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr,
			pwdata: wdata, pstrb: strb};
		@(posedge clk);
		#1;
		drive_side(data_side, req);
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		drive_side(data_side, req);
		@(negedge clk);
		rsp = data_side ? d_rsp : i_rsp;
		while (!rsp.pready)
		begin
			@(negedge clk);
			rsp = data_side ? d_rsp : i_rsp;
		end
		@(posedge clk);
		#1;
		drive_side(data_side, '0);
	endtask

	task automatic write_word(input waddr_t wa, input logic [31:0] wd, input logic [3:0] st);
		apb_rsp_t rsp;
		apb_access(1'b1, 1'b1, 32'(wa) << 2, wd, st, rsp);
		check_err("data write", rsp, 1'b0);
		for (int b = 0; b < 4; b++)
			if (st[b]) model_mem[wa][8*b +: 8] = wd[8*b +: 8];
	endtask

	task automatic read_word(input string name, input waddr_t wa);
		apb_rsp_t rsp;
		apb_access(1'b1, 1'b0, 32'(wa) << 2, '0, '0, rsp);
		check_rdata(name, rsp, model_mem[wa]);
	endtask

	task automatic fetch_word(input string name, input waddr_t wa);
		apb_rsp_t rsp;
		apb_access(1'b0, 1'b0, 32'(wa) << 2, '0, '0, rsp);
		check_rdata(name, rsp, exp_fetch(wa));
	endtask

	initial
	begin
		apb_rsp_t    rsp;
		waddr_t      wa;
		logic [31:0] wd;
		logic [3:0]  st;
		i_req = '0;
		d_req = '0;
		reset = 1'b1;
		lfsr  = 16'd52688;
		for (int i = 0; i < `ICACHE_LINES; i++)
			line_ok[i] = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_idle("idle fetch side", i_rsp);
		check_idle("idle data side", d_rsp);

		for (int a = 0; a < 2 * REGION; a++)
			write_word(waddr_t'(a), rand_bits(32), 4'hf);   // Known contents everywhere used

		for (int n = 0; n < N_WRITES; n++)
		begin
			wa = waddr_t'(REGION + rand_bits(8));
			wd = rand_bits(32);
			st = 4'(rand_bits(4));
			write_word(wa, wd, st);
			read_word("strobed readback", wa);
			read_word("random read", waddr_t'(REGION + rand_bits(8)));
		end

		for (int a = 0; a < ALIAS_STEP; a++)
			fetch_word("first fetch pass", waddr_t'(a));
		for (int a = 0; a < ALIAS_STEP; a++)
			fetch_word("second fetch pass", waddr_t'(a));
		for (int n = 0; n < 64; n++)
		begin
			wa = waddr_t'(rand_bits(8));
			fetch_word("aliased fetch", wa);
			fetch_word("aliased fetch", wa ^ waddr_t'(ALIAS_STEP));   // Same index, other tag
		end

		// Data stays above the fetch region so fill contents are well defined
		for (int n = 0; n < N_PAR; n++)
		begin
			par_fetch[n] = waddr_t'(rand_bits(8));
			par_write[n] = 1'(rand_bits(1));
			par_addr[n]  = waddr_t'(REGION + rand_bits(8));
			par_data[n]  = rand_bits(32);
			par_strb[n]  = 4'(rand_bits(4));
		end
		fork
			for (int n = 0; n < N_PAR; n++)
				fetch_word("parallel fetch", par_fetch[n]);
			for (int n = 0; n < N_PAR; n++)
			begin
				if (par_write[n])
					write_word(par_addr[n], par_data[n], par_strb[n]);
				else
					read_word("parallel read", par_addr[n]);
			end
		join

		wa = waddr_t'(rand_bits(8));
		apb_access(1'b0, 1'b1, 32'(wa) << 2, 32'hdead_beef, 4'hf, rsp);
		check_err("fetch side write", rsp, 1'b1);
		apb_access(1'b0, 1'b0, RAM_BYTES | (32'(wa) << 2), '0, '0, rsp);
		check_err("fetch above RAM", rsp, 1'b1);
		apb_access(1'b1, 1'b1, RAM_BYTES | (32'(wa) << 2), 32'hdead_beef, 4'hf, rsp);
		check_err("data write above RAM", rsp, 1'b1);
		apb_access(1'b1, 1'b0, 32'h8000_0000, '0, '0, rsp);
		check_err("data read above RAM", rsp, 1'b1);
		read_word("memory unchanged", wa);

		// Icache is not coherent with data writes
		wa = waddr_t'(rand_bits(8));
		fetch_word("line warm-up", wa);
		write_word(wa, ~model_mem[wa], 4'hf);
		fetch_word("stale fetch", wa);
		fetch_word("evicting fetch", wa ^ waddr_t'(ALIAS_STEP));
		fetch_word("fetch after eviction", wa);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mem_sys_pkg.sv
bus_arbiter.sv
icache.sv
data_port.sv
block_ram.sv
mem_system.sv
mem_system_properties.sv
tb_mem_system.sv
